// ==== include/tile_video_consts.svh ====
// ************************************************************
// Tile video constants
// Display geometry, host register map, ID value and the
// pixel pipeline depth shared by the display controller
// ************************************************************

`ifndef TILE_VIDEO_CONSTS_SVH
`define TILE_VIDEO_CONSTS_SVH

// Horizontal geometry in clocks
`define TV_H_VISIBLE 16
`define TV_H_FRONT 4
`define TV_H_SYNC 8
`define TV_H_TOTAL 128

// Vertical geometry in lines
`define TV_V_VISIBLE 8
`define TV_V_FRONT 1
`define TV_V_SYNC 2
`define TV_V_TOTAL 12

`define TV_WORDS_PER_LINE 4  // 16-bit words of 4-bit indices
`define TV_PIX_LATENCY 2     // Position to rgb, in clocks

// Host register map
`define TV_REG_CTRL 8'h00
`define TV_REG_VRAM_BASE 8'h01
`define TV_REG_STATUS 8'h02
`define TV_REG_ID 8'h03
`define TV_PAL_BASE 8'h10
`define TV_ID_VALUE 16'h7C01

`endif

// ==== hw/tile_video_pkg.sv ====
// ************************************************************
// Tile video package
// Vector types, bus structs and the fetcher state encoding
// ************************************************************

package tile_video_pkg;

  typedef logic [7:0]  mpu_addr_t;
  typedef logic [15:0] word_t;       // Host and VRAM data
  typedef logic [15:0] vram_addr_t;  // VRAM word address
  typedef logic [3:0]  pix_index_t;
  typedef logic [11:0] rgb_t;        // 4:4:4
  typedef logic [6:0]  hpos_t;
  typedef logic [3:0]  vpos_t;

  // One host access, valid for a single clock
  typedef struct packed {
    logic      en;
    logic      wr;
    mpu_addr_t addr;
    word_t     wdata;
  } mpu_req_t;

  typedef struct packed {
    logic       en;
    pix_index_t index;
    rgb_t       rgb;
  } pal_wr_t;

  typedef struct packed {
    logic       show;   // Low forces black
    pix_index_t index;
  } pix_t;

  // Sync is active low
  typedef struct packed {
    logic hsync;
    logic vsync;
    logic de;
  } video_t;

  typedef enum logic [1:0] {IDLE, REQ, WAIT_ACK_LOW, DONE} fetch_state_e;

endpackage

// ==== hw/mpu_regs.sv ====
// ************************************************************
// Host register block
// Decodes host accesses, holds control and VRAM base, keeps
// the sticky underrun flag and routes palette writes
// ************************************************************

`timescale 1ns/1ps
`include "tile_video_consts.svh"

module mpu_regs (
  input  logic                       clk,
  input  logic                       rst_n,
  input  tile_video_pkg::mpu_req_t   mpu_req,
  input  tile_video_pkg::vpos_t      v_pos,
  input  logic                       underrun_pulse,
  output tile_video_pkg::word_t      mpu_rdata,
  output logic                       display_on,
  output tile_video_pkg::vram_addr_t vram_base,
  output tile_video_pkg::pal_wr_t    pal_wr
);

  tile_video_pkg::word_t ctrl;
  tile_video_pkg::word_t rd_mux;
  logic                  underrun;
  logic                  rd_en;
  logic                  wr_en;
  logic                  pal_sel;
  logic                  status_clr;

  assign rd_en   = mpu_req.en && !mpu_req.wr;
  assign wr_en   = mpu_req.en && mpu_req.wr;
  assign pal_sel = ((mpu_req.addr & 8'hF0) == `TV_PAL_BASE);  // 16 entries

  assign display_on = ctrl[0];

  // Palette write lands at the same edge as the host write
  assign pal_wr.en    = wr_en && pal_sel;
  assign pal_wr.index = mpu_req.addr[3:0];
  assign pal_wr.rgb   = mpu_req.wdata[11:0];

  // Write 1 to status bit 0 to clear
  assign status_clr = wr_en && (mpu_req.addr == `TV_REG_STATUS) && mpu_req.wdata[0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl      <= '0;
      vram_base <= '0;
    end else if (wr_en) begin
      case (mpu_req.addr)
        `TV_REG_CTRL:      ctrl <= mpu_req.wdata;
        `TV_REG_VRAM_BASE: vram_base <= mpu_req.wdata;
        default: ;
      endcase
    end
  end

  // Sticky, a new underrun wins over a clear
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      underrun <= 1'b0;
    end else if (underrun_pulse) begin
      underrun <= 1'b1;
    end else if (status_clr) begin
      underrun <= 1'b0;
    end
  end

  // Palette and unmapped addresses read as zero
  always_comb begin
    case (mpu_req.addr)
      `TV_REG_CTRL:      rd_mux = ctrl;
      `TV_REG_VRAM_BASE: rd_mux = vram_base;
      `TV_REG_STATUS:    rd_mux = {4'b0, v_pos, 7'b0, underrun};
      `TV_REG_ID:        rd_mux = `TV_ID_VALUE;
      default:           rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mpu_rdata <= '0;
    end else if (rd_en) begin
      mpu_rdata <= rd_mux;  // Valid the clock after the read
    end
  end

endmodule

// ==== hw/display_timer.sv ====
// ************************************************************
// Display timing generator
// Pixel and line counters, sync and blank decode, line and
// fetch events, and the delayed sync set for the outputs
// ************************************************************

`timescale 1ns/1ps
`include "tile_video_consts.svh"

module display_timer (
  input  logic                   clk,
  input  logic                   rst_n,
  output tile_video_pkg::hpos_t  h_pos,
  output tile_video_pkg::vpos_t  v_pos,
  output logic                   de_raw,
  output logic                   line_start,
  output logic                   fetch_start,
  output tile_video_pkg::vpos_t  fetch_line,
  output tile_video_pkg::video_t video
);

  tile_video_pkg::video_t video_raw;
  tile_video_pkg::video_t video_pipe [`TV_PIX_LATENCY];
  logic                   h_last;
  logic                   v_last;
  logic                   v_vis;

  assign h_last = (h_pos == tile_video_pkg::hpos_t'(`TV_H_TOTAL - 1));
  assign v_last = (v_pos == tile_video_pkg::vpos_t'(`TV_V_TOTAL - 1));
  assign v_vis  = (v_pos < tile_video_pkg::vpos_t'(`TV_V_VISIBLE));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      h_pos <= '0;
      v_pos <= '0;
    end else if (h_last) begin
      h_pos <= '0;
      v_pos <= v_last ? '0 : v_pos + 1'b1;
    end else begin
      h_pos <= h_pos + 1'b1;
    end
  end

  assign de_raw     = v_vis && (h_pos < tile_video_pkg::hpos_t'(`TV_H_VISIBLE));
  assign line_start = v_vis && (h_pos == '0);

  // Fetch the next line right after the visible part of this one
  assign fetch_line  = v_last ? '0 : v_pos + 1'b1;
  assign fetch_start = (h_pos == tile_video_pkg::hpos_t'(`TV_H_VISIBLE)) &&
                       (fetch_line < tile_video_pkg::vpos_t'(`TV_V_VISIBLE));

  assign video_raw.hsync =
    !((h_pos >= tile_video_pkg::hpos_t'(`TV_H_VISIBLE + `TV_H_FRONT)) &&
      (h_pos < tile_video_pkg::hpos_t'(`TV_H_VISIBLE + `TV_H_FRONT + `TV_H_SYNC)));
  assign video_raw.vsync =
    !((v_pos >= tile_video_pkg::vpos_t'(`TV_V_VISIBLE + `TV_V_FRONT)) &&
      (v_pos < tile_video_pkg::vpos_t'(`TV_V_VISIBLE + `TV_V_FRONT + `TV_V_SYNC)));
  assign video_raw.de = de_raw;

  // Match the line buffer and palette register stages
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `TV_PIX_LATENCY; i++) begin
        video_pipe[i] <= '{hsync: 1'b1, vsync: 1'b1, de: 1'b0};
      end
    end else begin
      video_pipe[0] <= video_raw;
      for (int i = 1; i < `TV_PIX_LATENCY; i++) begin
        video_pipe[i] <= video_pipe[i-1];
      end
    end
  end

  assign video = video_pipe[`TV_PIX_LATENCY-1];

endmodule

// ==== hw/line_fetcher.sv ====
// ************************************************************
// Line fetcher
// Reads one line of palette indices from VRAM with a
// four-phase req/ack handshake and flags late lines
// ************************************************************

`timescale 1ns/1ps
`include "tile_video_consts.svh"

module line_fetcher (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       display_on,
  input  tile_video_pkg::vram_addr_t vram_base,
  input  logic                       fetch_start,
  input  tile_video_pkg::vpos_t      fetch_line,
  input  logic                       line_start,
  output logic                       vram_req,
  output tile_video_pkg::vram_addr_t vram_addr,
  input  logic                       vram_ack,
  input  tile_video_pkg::word_t      vram_rdata,
  output logic                       buf_we,
  output logic [1:0]                 buf_addr,
  output tile_video_pkg::word_t      buf_data,
  output logic                       line_ready,
  output logic                       underrun_pulse
);

  tile_video_pkg::fetch_state_e state;
  logic [1:0]                   word_cnt;
  logic                         late;       // Line start passed mid-fetch
  logic                         busy;
  logic                         last_word;

  assign busy      = (state == tile_video_pkg::REQ) || (state == tile_video_pkg::WAIT_ACK_LOW);
  assign last_word = (word_cnt == 2'(`TV_WORDS_PER_LINE - 1));

  assign vram_req = (state == tile_video_pkg::REQ);
  assign buf_we   = vram_req && vram_ack;  // Capture while ack is high
  assign buf_addr = word_cnt;
  assign buf_data = vram_rdata;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state          <= tile_video_pkg::IDLE;
      word_cnt       <= '0;
      vram_addr      <= '0;
      late           <= 1'b0;
      line_ready     <= 1'b0;
      underrun_pulse <= 1'b0;
    end else begin
      underrun_pulse <= line_start && busy;
      if (fetch_start) begin
        line_ready <= 1'b0;
      end
      if (line_start && busy) begin
        late <= 1'b1;
      end
      case (state)
        tile_video_pkg::IDLE, tile_video_pkg::DONE: begin
          if (fetch_start && display_on) begin
            state     <= tile_video_pkg::REQ;
            word_cnt  <= '0;
            late      <= 1'b0;
            vram_addr <= vram_base + tile_video_pkg::vram_addr_t'(fetch_line) *
                         tile_video_pkg::vram_addr_t'(`TV_WORDS_PER_LINE);
          end else if (line_start) begin
            state <= tile_video_pkg::IDLE;  // Line is on screen now
          end
        end
        tile_video_pkg::REQ: begin
          if (vram_ack) begin
            state <= tile_video_pkg::WAIT_ACK_LOW;
          end
        end
        tile_video_pkg::WAIT_ACK_LOW: begin
          if (!vram_ack) begin
            if (last_word) begin
              // A late line stays black for its whole span
              line_ready <= !(late || line_start);
              state      <= (late || line_start) ? tile_video_pkg::IDLE : tile_video_pkg::DONE;
            end else begin
              word_cnt  <= word_cnt + 1'b1;
              vram_addr <= vram_addr + 1'b1;
              state     <= tile_video_pkg::REQ;
            end
          end
        end
        default: state <= tile_video_pkg::IDLE;
      endcase
    end
  end

endmodule

// ==== hw/line_buffer.sv ====
// ************************************************************
// Line buffer
// Holds one fetched line and picks the palette index for
// the current pixel
// ************************************************************

`timescale 1ns/1ps

module line_buffer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  buf_we,
  input  logic [1:0]            buf_addr,
  input  tile_video_pkg::word_t buf_data,
  input  tile_video_pkg::hpos_t h_pos,
  input  logic                  de_raw,
  input  logic                  line_ready,
  input  logic                  display_on,
  output tile_video_pkg::pix_t  pix
);

  tile_video_pkg::word_t mem [4];
  tile_video_pkg::word_t cur_word;

  always_ff @(posedge clk) begin
    if (buf_we) begin
      mem[buf_addr] <= buf_data;
    end
  end

  assign cur_word = mem[h_pos[3:2]];  // Four pixels per word

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pix <= '0;
    end else begin
      pix.show  <= de_raw && line_ready && display_on;
      pix.index <= cur_word[{h_pos[1:0], 2'b00} +: 4];  // Pixel 0 in bits 3:0
    end
  end

endmodule

// ==== hw/palette_ram.sv ====
// ************************************************************
// Palette
// 16-entry 4:4:4 colour table with a host write port and a
// registered pixel lookup
// ************************************************************

`timescale 1ns/1ps

module palette_ram (
  input  logic                    clk,
  input  logic                    rst_n,
  input  tile_video_pkg::pal_wr_t pal_wr,
  input  tile_video_pkg::pix_t    pix,
  output tile_video_pkg::rgb_t    rgb
);

  tile_video_pkg::rgb_t table_q [16];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 16; i++) begin
        table_q[i] <= '0;
      end
    end else if (pal_wr.en) begin
      table_q[pal_wr.index] <= pal_wr.rgb;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rgb <= '0;
    end else begin
      rgb <= pix.show ? table_q[pix.index] : '0;  // Black in blanking
    end
  end

endmodule

// ==== hw/tile_video_top.sv ====
// ************************************************************
// Tile video display controller
// Host registers, timing, VRAM line fetch, line buffer and
// palette lookup to 12-bit RGB
// ************************************************************

`timescale 1ns/1ps

module tile_video_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  tile_video_pkg::mpu_req_t   mpu_req,
  output tile_video_pkg::word_t      mpu_rdata,
  output logic                       vram_req,
  output tile_video_pkg::vram_addr_t vram_addr,
  input  logic                       vram_ack,
  input  tile_video_pkg::word_t      vram_rdata,
  output logic                       hsync,
  output logic                       vsync,
  output logic                       de,
  output tile_video_pkg::rgb_t       rgb
);

  tile_video_pkg::vram_addr_t vram_base;
  tile_video_pkg::pal_wr_t    pal_wr;
  tile_video_pkg::hpos_t      h_pos;
  tile_video_pkg::vpos_t      v_pos;
  tile_video_pkg::vpos_t      fetch_line;
  tile_video_pkg::video_t     video;
  tile_video_pkg::pix_t       pix;
  tile_video_pkg::word_t      buf_data;
  logic [1:0]                 buf_addr;
  logic                       buf_we;
  logic                       display_on;
  logic                       underrun_pulse;
  logic                       de_raw;
  logic                       line_start;
  logic                       fetch_start;
  logic                       line_ready;

  mpu_regs u_regs (
    .clk(clk), .rst_n(rst_n), .mpu_req(mpu_req), .v_pos(v_pos),
    .underrun_pulse(underrun_pulse), .mpu_rdata(mpu_rdata),
    .display_on(display_on), .vram_base(vram_base), .pal_wr(pal_wr)
  );

  display_timer u_timer (
    .clk(clk), .rst_n(rst_n), .h_pos(h_pos), .v_pos(v_pos), .de_raw(de_raw),
    .line_start(line_start), .fetch_start(fetch_start), .fetch_line(fetch_line),
    .video(video)
  );

  line_fetcher u_fetch (
    .clk(clk), .rst_n(rst_n), .display_on(display_on), .vram_base(vram_base),
    .fetch_start(fetch_start), .fetch_line(fetch_line), .line_start(line_start),
    .vram_req(vram_req), .vram_addr(vram_addr), .vram_ack(vram_ack),
    .vram_rdata(vram_rdata), .buf_we(buf_we), .buf_addr(buf_addr),
    .buf_data(buf_data), .line_ready(line_ready), .underrun_pulse(underrun_pulse)
  );

  line_buffer u_lbuf (
    .clk(clk), .rst_n(rst_n), .buf_we(buf_we), .buf_addr(buf_addr),
    .buf_data(buf_data), .h_pos(h_pos), .de_raw(de_raw), .line_ready(line_ready),
    .display_on(display_on), .pix(pix)
  );

  palette_ram u_pal (
    .clk(clk), .rst_n(rst_n), .pal_wr(pal_wr), .pix(pix), .rgb(rgb)
  );

  assign {hsync, vsync, de} = video;  // Already aligned with rgb

endmodule

// ==== verif/tb_clock_gen.sv ====
// ************************************************************
// Testbench clock and reset
// 40 ns clock, reset held low for five cycles
// ************************************************************

`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  localparam int half_period_ns = 20;

  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
    forever #(half_period_ns) clk = ~clk;
  end

  initial begin
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

// ==== verif/tile_video_tb.sv ====
// ************************************************************
// Tile video testbench
// Host register access, VRAM responder, pixel reference
// model, sync shape checks and watchdog
// ************************************************************

`timescale 1ns/1ps
`include "tile_video_consts.svh"

module tile_video_tb;

  localparam longint watchdog_ns = 14 * 1536 * 40 + 10000;

  logic                       clk;
  logic                       rst_n;
  tile_video_pkg::mpu_req_t   mpu_req;
  tile_video_pkg::word_t      mpu_rdata;
  logic                       vram_req;
  tile_video_pkg::vram_addr_t vram_addr;
  logic                       vram_ack;
  tile_video_pkg::word_t      vram_rdata;
  logic                       hsync;
  logic                       vsync;
  logic                       de;
  tile_video_pkg::rgb_t       rgb;

  tile_video_pkg::word_t vram_mem [256];
  tile_video_pkg::rgb_t  pal_model [16];
  int model_base;
  int check_mode;   // 1 compares pixels, 0 expects black
  int slow_mode;    // Long ack delays for underrun

  tb_clock_gen u_clk (.clk(clk), .rst_n(rst_n));

  tile_video_top u_dut (
    .clk(clk), .rst_n(rst_n), .mpu_req(mpu_req), .mpu_rdata(mpu_rdata),
    .vram_req(vram_req), .vram_addr(vram_addr), .vram_ack(vram_ack),
    .vram_rdata(vram_rdata), .hsync(hsync), .vsync(vsync), .de(de), .rgb(rgb)
  );

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("error: time %0t signal %s actual %0h expected %0h",
               $time, name, actual, expected);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  // Palette entry of the nibble at base + line * 4 + x / 4
  function automatic tile_video_pkg::rgb_t expected_rgb(input int line, input int x);
    tile_video_pkg::word_t w;
    logic [3:0]            nib;
    w   = vram_mem[(model_base + line * 4 + x / 4) % 256];
    nib = w[(x % 4) * 4 +: 4];
    return pal_model[nib];
  endfunction

  task automatic host_write(input tile_video_pkg::mpu_addr_t addr,
                            input tile_video_pkg::word_t data);
    @(posedge clk);
    mpu_req <= '{en: 1'b1, wr: 1'b1, addr: addr, wdata: data};
    @(posedge clk);
    mpu_req <= '0;
  endtask

  task automatic host_read(input tile_video_pkg::mpu_addr_t addr,
                           output tile_video_pkg::word_t data);
    @(posedge clk);
    mpu_req <= '{en: 1'b1, wr: 1'b0, addr: addr, wdata: 16'h0};
    @(posedge clk);
    mpu_req <= '0;
    @(posedge clk);
    data = mpu_rdata;  // Registered the clock after the read
  endtask

  task automatic wait_clocks(input int n);
    repeat (n) @(posedge clk);
  endtask

  function automatic int ack_delay();
    if (slow_mode != 0) begin
      return 40;
    end
    return int'($urandom_range(6, 0));
  endfunction

  // VRAM responder, four-phase slave
  initial begin
    int addr;
    int word_num;
    word_num = 0;
    forever begin
      @(posedge clk);
      if (vram_req) begin
        // Words of a line in order, inside the 32-word frame region
        check_value("vram_addr_word", 32'(vram_addr[1:0]), 32'(word_num));
        check_value("vram_addr_region", 32'(vram_addr >> 5), 32'(model_base >> 5));
        word_num = (word_num + 1) % `TV_WORDS_PER_LINE;
        addr = int'(vram_addr[7:0]);
        wait_clocks(ack_delay());
        vram_rdata <= vram_mem[addr];
        vram_ack   <= 1'b1;
        do @(posedge clk); while (vram_req);
        wait_clocks(ack_delay());
        vram_ack <= 1'b0;
      end
    end
  end

  // Sync shape and pixel compare
  initial begin
    int cyc;
    int hs_low;
    int last_hs_fall;
    int last_vs_fall;
    int de_run;
    int de_lines;
    int line_cnt;
    logic hs_prev;
    logic vs_prev;
    logic de_prev;
    tile_video_pkg::rgb_t exp_rgb;
    cyc = 0;
    hs_low = 0;
    last_hs_fall = -1;
    last_vs_fall = -1;
    de_run = 0;
    de_lines = 0;
    line_cnt = 0;
    hs_prev = 1'b1;
    vs_prev = 1'b1;
    de_prev = 1'b0;
    forever begin
      @(posedge clk);
      if (rst_n) begin
        cyc++;
        if (!hsync) hs_low++;
        if (hsync && !hs_prev) begin
          check_value("hsync_low_clocks", 32'(hs_low), 32'd8);
          hs_low = 0;
        end
        if (!hsync && hs_prev) begin
          if (last_hs_fall >= 0) check_value("hsync_period", 32'(cyc - last_hs_fall), 32'd128);
          last_hs_fall = cyc;
        end
        if (!vsync && vs_prev) begin
          if (last_vs_fall >= 0) check_value("vsync_period", 32'(cyc - last_vs_fall), 32'd1536);
          check_value("de_lines", 32'(de_lines), 32'd8);
          last_vs_fall = cyc;
          de_lines = 0;
          line_cnt = 0;
        end
        if (de) begin
          exp_rgb = (check_mode == 1) ? expected_rgb(line_cnt, de_run) : '0;
          check_value("rgb", 32'(rgb), 32'(exp_rgb));
          de_run++;
        end else begin
          check_value("rgb", 32'(rgb), 32'd0);  // Black in blanking
          if (de_prev) begin
            check_value("de_high_clocks", 32'(de_run), 32'd16);
            de_lines++;
            line_cnt++;
          end
          de_run = 0;
        end
        hs_prev = hsync;
        vs_prev = vsync;
        de_prev = de;
      end
    end
  end

  // Watchdog
  initial begin
    #(watchdog_ns);
    $display("timeout: the run did not finish within %0d ns", watchdog_ns);
    $display("Simulation failed");
    $fatal(1);
  end

  task automatic check_req_idle(input int clocks);
    repeat (clocks) begin
      @(posedge clk);
      check_value("vram_req", 32'(vram_req), 32'd0);
    end
  endtask

  initial begin
    tile_video_pkg::word_t rd;
    int seed;
    mpu_req     <= '0;
    vram_ack    <= 1'b0;
    vram_rdata  <= '0;
    model_base  = 0;
    check_mode  = 0;
    slow_mode   = 0;
    seed = int'($urandom(64));
    @(posedge rst_n);
    wait_clocks(3);

    // Register read back
    host_write(`TV_REG_CTRL, 16'h00A4);
    host_read(`TV_REG_CTRL, rd);
    check_value("ctrl", 32'(rd), 32'h00A4);
    host_write(`TV_REG_VRAM_BASE, 16'h1234);
    host_read(`TV_REG_VRAM_BASE, rd);
    check_value("vram_base", 32'(rd), 32'h1234);
    host_write(`TV_REG_VRAM_BASE, 16'h0000);
    host_read(`TV_REG_ID, rd);
    check_value("id", 32'(rd), 32'h7C01);
    host_read(8'h05, rd);
    check_value("unmapped", 32'(rd), 32'h0);

    for (int i = 0; i < 256; i++) begin
      vram_mem[i] = 16'($urandom);
    end
    for (int i = 0; i < 16; i++) begin
      pal_model[i] = 12'($urandom);
      host_write(`TV_PAL_BASE + 8'(i), {4'h0, pal_model[i]});
    end

    // Loaded palette entries still read as zero
    host_read(8'h10, rd);
    check_value("palette_0", 32'(rd), 32'h0);
    host_read(8'h1F, rd);
    check_value("palette_15", 32'(rd), 32'h0);

    // Enable display in vertical blank, check two frames
    @(negedge vsync);
    check_mode = 1;
    host_write(`TV_REG_CTRL, 16'h0001);
    @(negedge vsync);
    @(negedge vsync);

    // New base takes effect on the next frame
    model_base = 'h40;
    host_write(`TV_REG_VRAM_BASE, 16'h0040);
    @(negedge vsync);

    // Slow VRAM, every line late
    slow_mode  = 1;
    check_mode = 0;
    @(negedge vsync);
    slow_mode  = 0;
    check_mode = 1;
    host_read(`TV_REG_STATUS, rd);
    check_value("status_underrun", 32'(rd[0]), 32'd1);
    check_value("status_line", 32'(rd[11:8]), 32'(`TV_V_VISIBLE + `TV_V_FRONT));
    host_write(`TV_REG_STATUS, 16'h0001);
    host_read(`TV_REG_STATUS, rd);
    check_value("status_underrun", 32'(rd[0]), 32'd0);
    @(negedge vsync);

    // Display off, no fetch for a whole frame
    check_mode = 0;
    host_write(`TV_REG_CTRL, 16'h0000);
    check_req_idle(1536);
    host_read(`TV_REG_STATUS, rd);
    check_value("status_underrun", 32'(rd[0]), 32'd0);

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// ==== tile_video.f ====
+incdir+include
hw/tile_video_pkg.sv
hw/mpu_regs.sv
hw/display_timer.sv
hw/line_fetcher.sv
hw/line_buffer.sv
hw/palette_ram.sv
hw/tile_video_top.sv
verif/tb_clock_gen.sv
verif/tile_video_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the tile_video testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -f tile_video.f --top-module tile_video_tb -o tile_video_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tile_video_sim > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Simulation failed" sim.log; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulator returned status $status"
  exit 1
fi
exit 0
